// ==== acq_cfg_pkg.sv ====
`default_nettype none

package acq_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // adc side
    localparam int adc_sample_w    = 12;    // one adc sample, over-range bit excluded
    localparam int adc_pair_w      = 26;    // two samples, each with its over-range bit
    localparam int lane_w          = 16;    // one sign-extended lane
    localparam int lanes_per_burst = 8;
    localparam int pairs_per_burst = 4;     // pairs captured per burst

    //////////////////////////////////////////////////////////////////////
    // fill configuration fields
    localparam int num_bursts_w    = 14;    // data bursts per fill
    localparam int pre_trig_w      = 16;    // pre-trigger adc pairs
    localparam int burst_adr_w     = 23;    // first memory burst of the fill
    localparam int fill_num_w      = 24;
    localparam int channel_tag_w   = 12;
    localparam int alarm_w         = 4;     // xadc alarm bits
    localparam int fill_type_w     = 2;

    //////////////////////////////////////////////////////////////////////
    // constant header fields in cbuf mode
    localparam int adr_pad_w       = 3;     // burst address goes out with 3 zero lsbs
    localparam int wave_cnt_w      = 12;    // final waveform count, always 1
    localparam int wave_idx_w      = 23;    // waveform index, always 1
    localparam int pre_lo_w        = 12;    // pre-trigger bits kept in the low field

endpackage

`default_nettype wire

// ==== acq_fmt_pkg.sv ====
`default_nettype none

package acq_fmt_pkg;

    //////////////////////////////////////////////////////////////////////
    // burst word: 4-bit contents tag over a 128-bit payload
    localparam int tag_w       = 4;
    localparam int payload_w   = acq_cfg_pkg::lanes_per_burst * acq_cfg_pkg::lane_w;
    localparam int burst_w     = tag_w + payload_w;     // 132
    localparam int hdr_field_w = payload_w - 2;         // below the marker

    localparam logic [tag_w-1:0] tag_fill_hdr = 4'd1;
    localparam logic [tag_w-1:0] tag_wave_hdr = 4'd2;
    localparam logic [tag_w-1:0] tag_data     = 4'd3;
    localparam logic [tag_w-1:0] tag_checksum = 4'd4;

    // top two bits of sign-extended data are always 00 or 11
    localparam logic [1:0] hdr_marker = 2'b01;

    //////////////////////////////////////////////////////////////////////
    // fill header field lsbs
    localparam int fh_num_lsb    = 0;
    localparam int fh_type_lsb   = 24;
    localparam int fh_bursts_lsb = 27;
    localparam int fh_adr_lsb    = 50;      // address << 3
    localparam int fh_wcnt_lsb   = 76;
    localparam int fh_pre_lsb    = 88;
    localparam int fh_tag_lsb    = 110;
    localparam int fh_cbuf_bit   = 122;

    // waveform header field lsbs
    localparam int wh_bursts_lsb = 0;
    localparam int wh_prelo_lsb  = 14;
    localparam int wh_adr_lsb    = 26;      // address << 3
    localparam int wh_idx_lsb    = 52;
    localparam int wh_prehi_lsb  = 75;
    localparam int wh_tag_lsb    = 98;
    localparam int wh_alarm_lsb  = 110;
    localparam int wh_cbuf_bit   = 114;

    // word select from sequencer to combiner
    typedef enum logic [1:0] {
        sel_fill,
        sel_wave,
        sel_data,
        sel_sum
    } sel_e;

    // one payload, two readings
    typedef union packed {
        logic [acq_cfg_pkg::lanes_per_burst-1:0][acq_cfg_pkg::lane_w-1:0] lanes;
        struct packed {
            logic [1:0]             marker;     // 127:126
            logic [hdr_field_w-1:0] fields;
        } hdr;
    } acq_payload_u;

endpackage

`default_nettype wire

// ==== acq_fill_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module acq_fill_ctrl (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 fill_req,
    input  logic [acq_cfg_pkg::num_bursts_w-1:0] num_bursts,
    input  logic                                 burst_full,
    input  logic                                 word_done,
    output logic                                 fill_ack,
    output acq_fmt_pkg::sel_e                    sel,
    output logic                                 word_load,
    output logic                                 burst_take
);
    import acq_cfg_pkg::*;
    import acq_fmt_pkg::*;

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_fill = 3'd1;
    localparam logic [2:0] st_wave = 3'd2;
    localparam logic [2:0] st_data = 3'd3;
    localparam logic [2:0] st_sum  = 3'd4;
    localparam logic [2:0] st_done = 3'd5;

    logic [2:0]              state;
    logic                    busy;          // word issued, combiner still handshaking
    logic [num_bursts_w-1:0] bursts_left;

    always_comb begin
        case (state)
            st_wave: sel = sel_wave;
            st_data: sel = sel_data;
            st_sum:  sel = sel_sum;
            default: sel = sel_fill;        // also idle and done, unused there
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            busy        <= 1'b0;
            bursts_left <= '0;
            fill_ack    <= 1'b0;
            word_load   <= 1'b0;
            burst_take  <= 1'b0;
        end else begin
            word_load  <= 1'b0;             // single-cycle strobes
            burst_take <= 1'b0;
            case (state)
                st_idle: begin
                    if (fill_req) begin
                        state       <= st_fill;
                        bursts_left <= num_bursts;
                    end
                end
                st_fill, st_wave, st_data, st_sum: begin
                    if (!busy) begin
                        // data words wait for the packer
                        if (state != st_data || burst_full) begin
                            word_load  <= 1'b1;
                            burst_take <= (state == st_data);
                            busy       <= 1'b1;
                        end
                    end else if (word_done) begin
                        busy <= 1'b0;
                        case (state)
                            st_fill: state <= st_wave;
                            st_wave: state <= (bursts_left == '0) ? st_sum : st_data;
                            st_data: begin
                                bursts_left <= bursts_left - 1'b1;
                                if (bursts_left == 1) state <= st_sum;
                            end
                            default: begin
                                state    <= st_done;    // checksum acked
                                fill_ack <= 1'b1;
                            end
                        endcase
                    end
                end
                default: begin
                    if (!fill_req) begin
                        fill_ack <= 1'b0;
                        state    <= st_idle;
                    end
                end
            endcase
        end
    end

    // a data word must find a captured burst waiting in the packer
    a_data_has_burst : assert property (@(posedge clk) disable iff (!arst_n)
        word_load && sel == sel_data |-> burst_full);

endmodule

`default_nettype wire

// ==== acq_hdr_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module acq_hdr_builder (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [acq_cfg_pkg::fill_num_w-1:0]    fill_num,
    input  logic [acq_cfg_pkg::fill_type_w-1:0]   fill_type,
    input  logic [acq_cfg_pkg::burst_adr_w-1:0]   burst_start_adr,
    input  logic [acq_cfg_pkg::num_bursts_w-1:0]  num_bursts,
    input  logic [acq_cfg_pkg::pre_trig_w-1:0]    pre_trig,
    input  logic [acq_cfg_pkg::channel_tag_w-1:0] channel_tag,
    input  logic [acq_cfg_pkg::alarm_w-1:0]       xadc_alarms,
    input  logic                                  alarm_latch,
    output acq_fmt_pkg::acq_payload_u             fill_hdr,
    output acq_fmt_pkg::acq_payload_u             wave_hdr
);
    import acq_cfg_pkg::*;
    import acq_fmt_pkg::*;

    logic [alarm_w-1:0]               alarms_q;     // frozen for the rest of the fill
    logic [alarm_w-1:0]               alarms;
    logic [burst_adr_w+adr_pad_w-1:0] byte_adr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alarms_q <= '0;
        end else if (alarm_latch) begin
            alarms_q <= xadc_alarms;
        end
    end

    // combiner takes the waveform header on the latching edge, so pass the live value
    assign alarms   = alarm_latch ? xadc_alarms : alarms_q;
    assign byte_adr = {burst_start_adr, {adr_pad_w{1'b0}}};

    //////////////////////////////////////////////////////////////////////
    // fill header
    always_comb begin
        fill_hdr                                          = '0;
        fill_hdr.hdr.marker                               = hdr_marker;
        fill_hdr.hdr.fields[fh_num_lsb +: fill_num_w]     = fill_num;
        fill_hdr.hdr.fields[fh_type_lsb +: fill_type_w]   = fill_type;
        fill_hdr.hdr.fields[fh_bursts_lsb +: num_bursts_w] = num_bursts;
        fill_hdr.hdr.fields[fh_adr_lsb +: burst_adr_w+adr_pad_w] = byte_adr;
        fill_hdr.hdr.fields[fh_wcnt_lsb +: wave_cnt_w]    = wave_cnt_w'(1);   // one trigger
        fill_hdr.hdr.fields[fh_pre_lsb +: pre_trig_w]     = pre_trig;
        fill_hdr.hdr.fields[fh_tag_lsb +: channel_tag_w]  = channel_tag;
        fill_hdr.hdr.fields[fh_cbuf_bit]                  = 1'b1;             // cbuf mode
    end

    //////////////////////////////////////////////////////////////////////
    // waveform header, pre-trigger split in two fields
    always_comb begin
        wave_hdr                                           = '0;
        wave_hdr.hdr.marker                                = hdr_marker;
        wave_hdr.hdr.fields[wh_bursts_lsb +: num_bursts_w] = num_bursts;
        wave_hdr.hdr.fields[wh_prelo_lsb +: pre_lo_w]      = pre_trig[pre_lo_w-1:0];
        wave_hdr.hdr.fields[wh_adr_lsb +: burst_adr_w+adr_pad_w] = byte_adr;
        wave_hdr.hdr.fields[wh_idx_lsb +: wave_idx_w]      = wave_idx_w'(1);  // only waveform
        wave_hdr.hdr.fields[wh_prehi_lsb +: pre_trig_w-pre_lo_w] =
            pre_trig[pre_trig_w-1:pre_lo_w];
        wave_hdr.hdr.fields[wh_tag_lsb +: channel_tag_w]   = channel_tag;
        wave_hdr.hdr.fields[wh_alarm_lsb +: alarm_w]       = alarms;
        wave_hdr.hdr.fields[wh_cbuf_bit]                   = 1'b1;
    end

endmodule

`default_nettype wire

// ==== acq_sample_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module acq_sample_packer (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               adc_req,
    input  logic [acq_cfg_pkg::adc_pair_w-1:0] adc_dat0,    // oldest pair
    input  logic [acq_cfg_pkg::adc_pair_w-1:0] adc_dat1,
    input  logic [acq_cfg_pkg::adc_pair_w-1:0] adc_dat2,
    input  logic [acq_cfg_pkg::adc_pair_w-1:0] adc_dat3,
    input  logic                               burst_take,
    output logic                               adc_ack,
    output logic                               burst_full,
    output acq_fmt_pkg::acq_payload_u          lanes
);
    import acq_cfg_pkg::*;
    import acq_fmt_pkg::*;

    logic [adc_pair_w-1:0] pairs [pairs_per_burst];
    acq_payload_u          lanes_d;
    logic                  capture;

    assign pairs[0] = adc_dat0;
    assign pairs[1] = adc_dat1;
    assign pairs[2] = adc_dat2;
    assign pairs[3] = adc_dat3;

    assign capture = adc_req && !adc_ack && !burst_full;    // held off while register full

    // drop over-range bits 0 and 13, sign-extend each sample into its lane
    always_comb begin
        for (int p = 0; p < pairs_per_burst; p++) begin
            lanes_d.lanes[2*p]   = lane_w'(signed'(pairs[p][adc_sample_w:1]));
            lanes_d.lanes[2*p+1] = lane_w'(signed'(pairs[p][adc_pair_w-1:adc_sample_w+2]));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            adc_ack    <= 1'b0;
            burst_full <= 1'b0;
        end else begin
            if (capture) begin
                adc_ack    <= 1'b1;
                burst_full <= 1'b1;
            end else if (burst_take) begin
                burst_full <= 1'b0;             // sequencer took it
            end
            if (adc_ack && !adc_req) adc_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) lanes <= lanes_d;
    end

    // adc side must hold its data until acked
    a_adc_stable : assert property (@(posedge clk) disable iff (!arst_n)
        adc_req && !adc_ack |=>
            $stable({adc_dat3, adc_dat2, adc_dat1, adc_dat0}) || adc_ack || !adc_req);

endmodule

`default_nettype wire

// ==== acq_burst_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module acq_burst_mux (
    input  logic                              clk,
    input  logic                              arst_n,
    input  acq_fmt_pkg::sel_e                 sel,
    input  logic                              word_load,
    input  acq_fmt_pkg::acq_payload_u         fill_hdr,
    input  acq_fmt_pkg::acq_payload_u         wave_hdr,
    input  acq_fmt_pkg::acq_payload_u         lanes,
    input  logic                              out_ack,
    output logic                              out_req,
    output logic [acq_fmt_pkg::burst_w-1:0]   out_dat,
    output logic                              word_done
);
    import acq_fmt_pkg::*;

    logic [payload_w-1:0] checksum;     // xor of every payload so far
    logic [tag_w-1:0]     tag;
    acq_payload_u         payload;
    logic                 ack_seen;     // out_req dropped, waiting for out_ack low

    always_comb begin
        case (sel)
            sel_fill: begin
                tag     = tag_fill_hdr;
                payload = fill_hdr;
            end
            sel_wave: begin
                tag     = tag_wave_hdr;
                payload = wave_hdr;
            end
            sel_data: begin
                tag     = tag_data;
                payload = lanes;
            end
            default: begin
                tag     = tag_checksum;
                payload = checksum;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            checksum <= '0;
        end else if (word_load) begin
            if (sel == sel_fill) checksum <= payload;               // new fill restarts it
            else if (sel != sel_sum) checksum <= checksum ^ payload;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output four-phase handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_req   <= 1'b0;
            ack_seen  <= 1'b0;
            word_done <= 1'b0;
        end else begin
            word_done <= 1'b0;
            if (word_load) begin
                out_req <= 1'b1;
            end else if (out_req && out_ack) begin
                out_req  <= 1'b0;
                ack_seen <= 1'b1;
            end else if (ack_seen && !out_ack) begin
                ack_seen  <= 1'b0;
                word_done <= 1'b1;                  // word fully handed off
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_load) out_dat <= {tag, payload};
    end

    // sequencer must wait for word_done before the next load
    a_load_idle : assert property (@(posedge clk) disable iff (!arst_n)
        word_load |-> !out_req && !ack_seen);

endmodule

`default_nettype wire

// ==== acq_cbuf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module acq_cbuf_top (
    input  logic                                  clk,
    input  logic                                  arst_n,
    // fill handshake and configuration
    input  logic                                  fill_req,
    output logic                                  fill_ack,
    input  logic [acq_cfg_pkg::fill_num_w-1:0]    fill_num,
    input  logic [acq_cfg_pkg::fill_type_w-1:0]   fill_type,
    input  logic [acq_cfg_pkg::burst_adr_w-1:0]   burst_start_adr,
    input  logic [acq_cfg_pkg::num_bursts_w-1:0]  num_bursts,
    input  logic [acq_cfg_pkg::pre_trig_w-1:0]    pre_trig,
    input  logic [acq_cfg_pkg::channel_tag_w-1:0] channel_tag,
    input  logic [acq_cfg_pkg::alarm_w-1:0]       xadc_alarms,
    // adc sample handshake
    input  logic                                  adc_req,
    output logic                                  adc_ack,
    input  logic [acq_cfg_pkg::adc_pair_w-1:0]    adc_dat0,
    input  logic [acq_cfg_pkg::adc_pair_w-1:0]    adc_dat1,
    input  logic [acq_cfg_pkg::adc_pair_w-1:0]    adc_dat2,
    input  logic [acq_cfg_pkg::adc_pair_w-1:0]    adc_dat3,
    // toward the memory write fifo
    output logic                                  out_req,
    input  logic                                  out_ack,
    output logic [acq_fmt_pkg::burst_w-1:0]       out_dat
);
    import acq_fmt_pkg::*;

    sel_e         sel;
    logic         word_load;
    logic         word_done;
    logic         burst_take;
    logic         burst_full;
    logic         alarm_latch;
    acq_payload_u fill_hdr;
    acq_payload_u wave_hdr;
    acq_payload_u lanes;

    assign alarm_latch = word_load && (sel == sel_wave);   // freeze alarms with the header

    acq_fill_ctrl i_acq_fill_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .fill_req   (fill_req),
        .num_bursts (num_bursts),
        .burst_full (burst_full),
        .word_done  (word_done),
        .fill_ack   (fill_ack),
        .sel        (sel),
        .word_load  (word_load),
        .burst_take (burst_take)
    );

    acq_hdr_builder i_acq_hdr_builder (
        .clk             (clk),
        .arst_n          (arst_n),
        .fill_num        (fill_num),
        .fill_type       (fill_type),
        .burst_start_adr (burst_start_adr),
        .num_bursts      (num_bursts),
        .pre_trig        (pre_trig),
        .channel_tag     (channel_tag),
        .xadc_alarms     (xadc_alarms),
        .alarm_latch     (alarm_latch),
        .fill_hdr        (fill_hdr),
        .wave_hdr        (wave_hdr)
    );

    acq_sample_packer i_acq_sample_packer (
        .clk        (clk),
        .arst_n     (arst_n),
        .adc_req    (adc_req),
        .adc_dat0   (adc_dat0),
        .adc_dat1   (adc_dat1),
        .adc_dat2   (adc_dat2),
        .adc_dat3   (adc_dat3),
        .burst_take (burst_take),
        .adc_ack    (adc_ack),
        .burst_full (burst_full),
        .lanes      (lanes)
    );

    acq_burst_mux i_acq_burst_mux (
        .clk       (clk),
        .arst_n    (arst_n),
        .sel       (sel),
        .word_load (word_load),
        .fill_hdr  (fill_hdr),
        .wave_hdr  (wave_hdr),
        .lanes     (lanes),
        .out_ack   (out_ack),
        .out_req   (out_req),
        .out_dat   (out_dat),
        .word_done (word_done)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);
    localparam time half_period = 2ns;     // 4 ns clock

    initial clk = 1'b0;

    always #(half_period) clk = ~clk;

endmodule

`default_nettype wire

// ==== tb_acq_cbuf.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_acq_cbuf;
    import acq_cfg_pkg::*;
    import acq_fmt_pkg::*;

    localparam int num_fills  = 6;
    localparam int max_bursts = 40;                             // largest count used
    localparam int burst_bits = pairs_per_burst * adc_pair_w;   // four pairs per burst

    logic                     clk;
    logic                     arst_n;
    logic                     fill_req;
    logic                     fill_ack;
    logic [fill_num_w-1:0]    fill_num;
    logic [fill_type_w-1:0]   fill_type;
    logic [burst_adr_w-1:0]   burst_start_adr;
    logic [num_bursts_w-1:0]  num_bursts;
    logic [pre_trig_w-1:0]    pre_trig;
    logic [channel_tag_w-1:0] channel_tag;
    logic [alarm_w-1:0]       xadc_alarms;
    logic                     adc_req;
    logic                     adc_ack;
    logic [adc_pair_w-1:0]    adc_dat0;
    logic [adc_pair_w-1:0]    adc_dat1;
    logic [adc_pair_w-1:0]    adc_dat2;
    logic [adc_pair_w-1:0]    adc_dat3;
    logic                     out_req;
    logic                     out_ack;
    logic [burst_w-1:0]       out_dat;

    // configuration of every fill, drawn before reset
    logic [fill_num_w-1:0]    cfg_num  [num_fills];
    logic [fill_type_w-1:0]   cfg_type [num_fills];
    logic [burst_adr_w-1:0]   cfg_adr  [num_fills];
    logic [num_bursts_w-1:0]  cfg_nb   [num_fills];
    logic [pre_trig_w-1:0]    cfg_pre  [num_fills];
    logic [channel_tag_w-1:0] cfg_tag  [num_fills];

    logic [burst_bits-1:0]    burst_q [$];  // samples of the current fill, oldest first
    logic [alarm_w-1:0]       exp_alarms;   // alarms present at the waveform header load
    int                       seed = 16653;
    int                       cur_fill;
    int                       cur_nb;
    int                       words_seen;   // output words seen in the current fill
    int                       err_mismatch = 0;
    int                       err_protocol = 0;
    int                       cycles = 0;
    int                       cycle_limit = 0;
    logic                     out_req_q = 1'b0;
    logic                     fill_ack_q = 1'b0;

    tb_clk_gen i_tb_clk_gen (
        .clk (clk)
    );

    acq_cbuf_top i_acq_cbuf_top (
        .clk             (clk),
        .arst_n          (arst_n),
        .fill_req        (fill_req),
        .fill_ack        (fill_ack),
        .fill_num        (fill_num),
        .fill_type       (fill_type),
        .burst_start_adr (burst_start_adr),
        .num_bursts      (num_bursts),
        .pre_trig        (pre_trig),
        .channel_tag     (channel_tag),
        .xadc_alarms     (xadc_alarms),
        .adc_req         (adc_req),
        .adc_ack         (adc_ack),
        .adc_dat0        (adc_dat0),
        .adc_dat1        (adc_dat1),
        .adc_dat2        (adc_dat2),
        .adc_dat3        (adc_dat3),
        .out_req         (out_req),
        .out_ack         (out_ack),
        .out_dat         (out_dat)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    function automatic logic [payload_w-1:0] expected_payload(input int idx);
        logic [payload_w-1:0]  p;
        logic [adc_pair_w-1:0] pair;
        logic [11:0]           lo;
        logic [11:0]           hi;
        p = '0;
        if (idx < 2) p[127:126] = 2'b01;                    // header marker
        if (idx == 0) begin
            p[fh_num_lsb +: 24]    = cfg_num[cur_fill];
            p[fh_type_lsb +: 2]    = cfg_type[cur_fill];
            p[fh_bursts_lsb +: 14] = cfg_nb[cur_fill];
            p[fh_adr_lsb +: 26]    = {cfg_adr[cur_fill], 3'b000};
            p[fh_wcnt_lsb +: 12]   = 12'd1;                 // single waveform
            p[fh_pre_lsb +: 16]    = cfg_pre[cur_fill];
            p[fh_tag_lsb +: 12]    = cfg_tag[cur_fill];
            p[fh_cbuf_bit]         = 1'b1;
        end else if (idx == 1) begin
            p[wh_bursts_lsb +: 14] = cfg_nb[cur_fill];
            p[wh_prelo_lsb +: 12]  = cfg_pre[cur_fill][11:0];
            p[wh_adr_lsb +: 26]    = {cfg_adr[cur_fill], 3'b000};
            p[wh_idx_lsb +: 23]    = 23'd1;
            p[wh_prehi_lsb +: 4]   = cfg_pre[cur_fill][15:12];
            p[wh_tag_lsb +: 12]    = cfg_tag[cur_fill];
            p[wh_alarm_lsb +: 4]   = exp_alarms;
            p[wh_cbuf_bit]         = 1'b1;
        end else begin
            for (int k = 0; k < pairs_per_burst; k++) begin
                pair = burst_q[idx-2][k*adc_pair_w +: adc_pair_w];
                lo   = pair[12:1];                          // over-range bits 0 and 13 dropped
                hi   = pair[25:14];
                p[32*k +: 16]      = {{4{lo[11]}}, lo};
                p[32*k + 16 +: 16] = {{4{hi[11]}}, hi};
            end
        end
        return p;
    endfunction

    function automatic logic [burst_w-1:0] build_expected(input int idx);
        logic [payload_w-1:0] sum;
        sum = '0;
        if (idx == 0) return {tag_fill_hdr, expected_payload(0)};
        if (idx == 1) return {tag_wave_hdr, expected_payload(1)};
        if (idx < cur_nb + 2) return {tag_data, expected_payload(idx)};
        for (int i = 0; i < cur_nb + 2; i++) begin
            sum = sum ^ expected_payload(i);                // fold every earlier payload
        end
        return {tag_checksum, sum};
    endfunction

    function automatic string word_name(input int idx);
        if (idx == 0) return "fill header";
        if (idx == 1) return "waveform header";
        if (idx < cur_nb + 2) return $sformatf("data %0d", idx - 2);
        return "checksum";
    endfunction

    //////////////////////////////////////////////////////////////////////
    // comparison at the out_req rising edge and while the word is held, sampled mid-cycle
    always @(negedge clk) begin : compare_words
        logic [burst_w-1:0] exp_word;
        string              name;
        if (arst_n && out_req && !out_req_q) begin
            name = $sformatf("fill %0d %s", cur_fill, word_name(words_seen));
            assert (words_seen < cur_nb + 3) else begin
                $display("fill %0d: extra output word after the checksum word", cur_fill);
                err_protocol++;
            end
            exp_word = build_expected(words_seen);
            assert (out_dat === exp_word) else begin
                $display("mismatch %s: expected %h, actual %h", name, exp_word, out_dat);
                err_mismatch++;
            end
            words_seen++;
        end
        if (arst_n && out_req && out_req_q) begin
            assert (out_dat === exp_word) else begin
                $display("mismatch %s while out_req held: expected %h, actual %h",
                         name, exp_word, out_dat);
                err_mismatch++;
            end
        end
        if (arst_n && fill_ack && !fill_ack_q) begin
            assert (words_seen == cur_nb + 3 && !out_req && !out_ack) else begin
                $display("fill %0d: fill_ack rose before the checksum word was acknowledged",
                         cur_fill);
                err_protocol++;
            end
        end
        out_req_q  = out_req;
        fill_ack_q = fill_ack;
    end

    // output side acks after 0 to 5 cycles
    initial begin : ack_responder
        int delay;
        forever begin
            @(negedge clk);
            if (out_req && !out_ack) begin
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(negedge clk);
                out_ack = 1'b1;
                do @(negedge clk); while (out_req);
                out_ack = 1'b0;                             // four-phase return to zero
            end
        end
    end

    task automatic feed_bursts();
        int gap;
        for (int i = 0; i < cur_nb; i++) begin
            gap = $unsigned($random(seed)) % 6;             // slow adc side
            repeat (gap) @(negedge clk);
            {adc_dat3, adc_dat2, adc_dat1, adc_dat0} = burst_q[i];
            adc_req = 1'b1;
            do @(negedge clk); while (!adc_ack);            // held off while packer is full
            adc_req = 1'b0;
            {adc_dat3, adc_dat2, adc_dat1, adc_dat0} =
                {$random(seed), $random(seed), $random(seed), $random(seed)};
            while (adc_ack) @(negedge clk);
        end
    endtask

    // alarms move once the waveform header is out, while it may still be held
    task automatic change_alarms();
        wait (words_seen >= 2);
        repeat (3) begin
            @(negedge clk);
            xadc_alarms = $random(seed);
        end
    endtask

    task automatic run_fill(input int f);
        @(negedge clk);
        cur_fill   = f;
        cur_nb     = cfg_nb[f];
        words_seen = 0;
        burst_q.delete();
        for (int i = 0; i < cur_nb; i++) begin
            burst_q.push_back({$random(seed), $random(seed), $random(seed), $random(seed)});
        end
        fill_num        = cfg_num[f];
        fill_type       = cfg_type[f];
        burst_start_adr = cfg_adr[f];
        num_bursts      = cfg_nb[f];
        pre_trig        = cfg_pre[f];
        channel_tag     = cfg_tag[f];
        xadc_alarms     = $random(seed);
        exp_alarms      = xadc_alarms;
        @(negedge clk);
        fill_req = 1'b1;
        fork
            feed_bursts();
            change_alarms();
        join
        while (!fill_ack) @(negedge clk);
        fill_req = 1'b0;
        while (fill_ack) @(negedge clk);
        assert (words_seen == cur_nb + 3) else begin
            $display("fill %0d: %0d output words, %0d expected", f, words_seen, cur_nb + 3);
            err_protocol++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    initial begin : stimulus
        arst_n          = 1'b0;
        fill_req        = 1'b0;
        fill_num        = '0;
        fill_type       = '0;
        burst_start_adr = '0;
        num_bursts      = '0;
        pre_trig        = '0;
        channel_tag     = '0;
        xadc_alarms     = '0;
        adc_req         = 1'b0;
        adc_dat0        = '0;
        adc_dat1        = '0;
        adc_dat2        = '0;
        adc_dat3        = '0;
        out_ack         = 1'b0;
        cur_fill        = 0;
        cur_nb          = 0;
        words_seen      = 0;
        for (int f = 0; f < num_fills; f++) begin
            if (f == 0) cfg_nb[f] = 1;                      // shortest fill
            else if (f == 1) cfg_nb[f] = max_bursts;
            else cfg_nb[f] = 1 + $unsigned($random(seed)) % 24;
            cfg_num[f]  = $random(seed);
            cfg_type[f] = $random(seed);
            cfg_adr[f]  = $random(seed);
            cfg_pre[f]  = $random(seed);
            cfg_tag[f]  = $random(seed);
        end
        cycle_limit = 200;
        for (int f = 0; f < num_fills; f++) cycle_limit += (3 + cfg_nb[f]) * 20;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        repeat (10) begin
            @(negedge clk);
            assert (!out_req && !fill_ack && !adc_ack) else begin
                $display("handshake output high after reset without fill_req");
                err_protocol++;
            end
        end
        for (int f = 0; f < num_fills; f++) run_fill(f);
        repeat (5) @(negedge clk);
        $display("errors: %0d mismatch, %0d protocol", err_mismatch, err_protocol);
        if (err_mismatch + err_protocol == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("errors: %0d mismatch, %0d protocol", err_mismatch, err_protocol);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
acq_cfg_pkg.sv
acq_fmt_pkg.sv
acq_fill_ctrl.sv
acq_hdr_builder.sv
acq_sample_packer.sv
acq_burst_mux.sv
acq_cbuf_top.sv
tb_clk_gen.sv
tb_acq_cbuf.sv

// ==== Bender.yml ====
package:
  name: acq_cbuf

sources:
  - acq_cfg_pkg.sv
  - acq_fmt_pkg.sv
  - acq_fill_ctrl.sv
  - acq_hdr_builder.sv
  - acq_sample_packer.sv
  - acq_burst_mux.sv
  - acq_cbuf_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_acq_cbuf.sv
